/* Makefile */
LOG = sim.log

sim:
	verilator --binary --timing --assert -f all.f --top-module tb_eeprom
	./obj_dir/Vtb_eeprom | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

/* all.f */
+incdir+bench
design/ee_pkg.sv
design/ee_cell_array.sv
design/ee_serial_decode.sv
design/ee_write_engine.sv
design/ee_read_shifter.sv
design/eeprom_93c46.sv
bench/tb_eeprom.sv

/* bench/ee_bus_tasks.svh */
// Drive point sits 2 ns after the rising edge
task automatic step(input int n);
	repeat (n) begin
		@(posedge sys_clk);
		#2;
	end
endtask

function automatic ee_pkg::ee_instr_u addr_instr(input logic [1:0] opc,
		input ee_pkg::ee_addr_t addr);
	ee_pkg::ee_instr_u ir;
	ir.adr.opc  = opc;
	ir.adr.addr = addr;
	return ir;
endfunction

function automatic ee_pkg::ee_instr_u ext_instr(input logic [1:0] code);
	ee_pkg::ee_instr_u ir;
	ir.ext.opc  = ee_pkg::OPC_EXT;
	ir.ext.code = code;
	ir.ext.dc   = 4'b1010;                      // Ignored by the part
	return ir;
endfunction

task automatic send_bit(input logic b);
	di = b;
	sk = 1'b0;
	step(SK_PHASE);
	sk = 1'b1;                                  // Sampled on this rise
	step(SK_PHASE);
endtask

// Leaves cs high and sk high after the last bit
task automatic send_instr(input ee_pkg::ee_instr_u ir, input logic with_data,
		input ee_pkg::ee_word_t data);
	cs = 1'b1;
	sk = 1'b0;
	step(2);
	send_bit(1'b1);                             // Start bit
	for (int i = 7; i >= 0; i--)
		send_bit(ir[i]);
	if (with_data) begin
		for (int i = ee_pkg::EE_DATA_W - 1; i >= 0; i--)
			send_bit(data[i]);
	end
	di = 1'b0;
endtask

task automatic release_cs;
	cs = 1'b0;
	sk = 1'b0;
	di = 1'b0;
	step(2);
endtask

task automatic wait_ready(input string what);
	int n;
	n  = 0;
	cs = 1'b1;
	sk = 1'b0;
	step(1);
	while (dout !== 1'b1 && n < READY_LIMIT) begin
		step(1);
		n++;
	end
	if (dout !== 1'b1) begin
		$display("Timeout in %s: do_o never went back to ready after %s", test_name, what);
		$display("Something failed");
		$fatal(1, "Ready wait timed out");
	end
endtask

// Write-class command, busy seen right after it, then ready
task automatic run_write_cmd(input ee_pkg::ee_instr_u ir, input logic with_data,
		input ee_pkg::ee_word_t data, input string what);
	send_instr(ir, with_data, data);
	check_level({what, " busy level"}, 1'b0, dout);
	release_cs();
	wait_ready(what);
	release_cs();
endtask

// READ of nbits data bits, cs dropped afterwards
task automatic read_word(input ee_pkg::ee_addr_t addr, input int nbits,
		output ee_pkg::ee_word_t word);
	word = '0;
	send_instr(addr_instr(ee_pkg::OPC_READ, addr), 1'b0, '0);
	check_level("dummy zero", 1'b0, dout);
	for (int i = 0; i < nbits; i++) begin
		sk = 1'b0;
		step(SK_PHASE);
		sk = 1'b1;
		step(SK_PHASE);
		word = {word[ee_pkg::EE_DATA_W-2:0], dout};     // MSB first
	end
	release_cs();
endtask

task automatic check_word(input string what, input ee_pkg::ee_word_t exp,
		input ee_pkg::ee_word_t act);
	if (act !== exp) begin
		$display("[FAIL] %s, %s: expected %h, actual %h", test_name, what, exp, act);
		$display("Something failed");
		$fatal(1, "Word mismatch");
	end
endtask

task automatic check_level(input string what, input logic exp, input logic act);
	if (act !== exp) begin
		$display("[FAIL] %s, %s: expected %b, actual %b", test_name, what, exp, act);
		$display("Something failed");
		$fatal(1, "Level mismatch");
	end
endtask

/* bench/tb_eeprom.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_eeprom;

	localparam int SK_PHASE    = 4;         // sys_clk cycles per sk phase
	localparam int READY_LIMIT = 1000;

	logic              sys_clk;
	logic              xresetl;
	logic              cs;
	logic              sk;
	logic              di;
	wire               dout;
	integer            seed = 32'h8bb2;
	string             test_name;
	logic              model_wen;           // Mirror of the write enable flag
	ee_pkg::ee_word_t  expected [ee_pkg::EE_WORDS];
	ee_pkg::ee_addr_t  written [10];
	ee_pkg::ee_word_t  got;

	eeprom_93c46 dut_i (
		.sys_clk (sys_clk),
		.xresetl (xresetl),
		.cs_i    (cs),
		.sk_i    (sk),
		.di_i    (di),
		.do_o    (dout)
	);

	`include "ee_bus_tasks.svh"

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	function automatic ee_pkg::ee_addr_t rand_addr();
		logic [31:0] r;
		r = $random(seed);
		return r[ee_pkg::EE_ADDR_W-1:0];
	endfunction

	function automatic ee_pkg::ee_word_t rand_word();
		logic [31:0] r;
		r = $random(seed);
		return r[ee_pkg::EE_DATA_W-1:0];
	endfunction

	// Stores land only with the flag set
	task automatic store_expected(input ee_pkg::ee_addr_t addr, input ee_pkg::ee_word_t data);
		if (model_wen)
			expected[addr] = data;
	endtask

	task automatic fill_expected(input ee_pkg::ee_word_t data);
		for (int i = 0; i < ee_pkg::EE_WORDS; i++)
			store_expected(ee_pkg::ee_addr_t'(i), data);
	endtask

	task automatic set_write_enable(input logic on);
		send_instr(ext_instr(on ? ee_pkg::EXT_EWEN : ee_pkg::EXT_EWDS), 1'b0, '0);
		release_cs();
		model_wen = on;
	endtask

	task automatic test_locked_write;
		ee_pkg::ee_addr_t a;
		ee_pkg::ee_word_t w;
		test_name = "locked_write";
		a = rand_addr();
		w = rand_word();
		check_level("do_o after reset", 1'b1, dout);
		cs = 1'b1;
		step(2);
		check_level("ready with cs high", 1'b1, dout);
		release_cs();
		run_write_cmd(addr_instr(ee_pkg::OPC_WRITE, a), 1'b1, w, "write");
		store_expected(a, w);
		read_word(a, ee_pkg::EE_DATA_W, got);
		check_word("read back", expected[a], got);
	endtask

	task automatic test_erase_all;
		ee_pkg::ee_addr_t a;
		ee_pkg::ee_word_t w;
		test_name = "erase_all";
		set_write_enable(1'b1);
		a = rand_addr();
		w = rand_word() & 16'h7fff;             // Never the erased value
		run_write_cmd(addr_instr(ee_pkg::OPC_WRITE, a), 1'b1, w, "write");
		store_expected(a, w);
		read_word(a, ee_pkg::EE_DATA_W, got);
		check_word("word before eral", expected[a], got);
		run_write_cmd(ext_instr(ee_pkg::EXT_ERAL), 1'b0, '0, "eral");
		fill_expected(ee_pkg::EE_ERASED);
		read_word(a, ee_pkg::EE_DATA_W, got);
		check_word("erased word", ee_pkg::EE_ERASED, got);
		for (int i = 0; i < 8; i++) begin
			read_word(rand_addr(), ee_pkg::EE_DATA_W, got);
			check_word("erased word", ee_pkg::EE_ERASED, got);
		end
	endtask

	task automatic test_write_words;
		ee_pkg::ee_word_t w;
		test_name = "write_words";
		for (int i = 0; i < 10; i++) begin
			written[i] = rand_addr();
			w = rand_word();
			run_write_cmd(addr_instr(ee_pkg::OPC_WRITE, written[i]), 1'b1, w, "write");
			store_expected(written[i], w);
		end
		for (int i = 0; i < 10; i++) begin
			read_word(written[i], ee_pkg::EE_DATA_W, got);
			check_word("written word", expected[written[i]], got);
		end
	endtask

	task automatic test_erase_word;
		ee_pkg::ee_addr_t a;
		test_name = "erase_word";
		run_write_cmd(addr_instr(ee_pkg::OPC_ERASE, written[0]), 1'b0, '0, "erase");
		store_expected(written[0], ee_pkg::EE_ERASED);
		for (int d = -1; d <= 1; d++) begin
			a = written[0] + ee_pkg::ee_addr_t'(d);   // Neighbours wrap at the ends
			read_word(a, ee_pkg::EE_DATA_W, got);
			check_word("erased or neighbour", expected[a], got);
		end
	endtask

	task automatic test_write_all;
		ee_pkg::ee_word_t w;
		test_name = "write_all";
		w = rand_word();
		run_write_cmd(ext_instr(ee_pkg::EXT_WRAL), 1'b1, w, "wral");
		fill_expected(w);
		for (int i = 0; i < 16; i++) begin
			read_word(rand_addr(), ee_pkg::EE_DATA_W, got);
			check_word("wral word", w, got);
		end
	endtask

	task automatic test_disable_abort;
		ee_pkg::ee_addr_t a;
		ee_pkg::ee_addr_t b;
		ee_pkg::ee_word_t w;
		test_name = "disable_abort";
		a = written[1];
		b = a + 6'd7;
		w = rand_word();
		run_write_cmd(addr_instr(ee_pkg::OPC_WRITE, a), 1'b1, w, "write a");
		store_expected(a, w);
		run_write_cmd(addr_instr(ee_pkg::OPC_WRITE, b), 1'b1, ~w, "write b");
		store_expected(b, ~w);
		set_write_enable(1'b0);
		run_write_cmd(addr_instr(ee_pkg::OPC_WRITE, a), 1'b1, rand_word(), "locked write");
		read_word(a, ee_pkg::EE_DATA_W, got);
		check_word("old value kept", expected[a], got);
		read_word(a, 5, got);                           // Cut short by cs low
		read_word(b, ee_pkg::EE_DATA_W, got);
		check_word("read after abort", expected[b], got);
	endtask

	initial begin
		xresetl   = 1'b0;
		cs        = 1'b0;
		sk        = 1'b0;
		di        = 1'b0;
		model_wen = 1'b0;
		test_name = "reset";
		for (int i = 0; i < ee_pkg::EE_WORDS; i++)
			expected[i] = ee_pkg::EE_ERASED;   // Blank part
		step(10);
		xresetl = 1'b1;
		step(2);
		test_locked_write();
		test_erase_all();
		test_write_words();
		test_erase_word();
		test_write_all();
		test_disable_abort();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* design/ee_cell_array.sv */
`timescale 1ns/100ps
`default_nettype none

module ee_cell_array (
	input  wire               sys_clk,
	input  wire               wr_en_i,
	input  ee_pkg::ee_addr_t  wr_addr_i,
	input  ee_pkg::ee_word_t  wr_data_i,
	input  ee_pkg::ee_addr_t  rd_addr_i,
	output ee_pkg::ee_word_t  rd_data_o
);

	ee_pkg::ee_word_t mem [ee_pkg::EE_WORDS];

	// Blank part comes up erased
	initial begin
		for (int i = 0; i < ee_pkg::EE_WORDS; i++)
			mem[i] = ee_pkg::EE_ERASED;
	end

	always @(posedge sys_clk) begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	assign rd_data_o = mem[rd_addr_i];      // Asynchronous read

endmodule

`default_nettype wire

/* design/ee_pkg.sv */
`default_nettype none

package ee_pkg;

	localparam int EE_ADDR_W = 6;
	localparam int EE_DATA_W = 16;
	localparam int EE_WORDS  = 1 << EE_ADDR_W;

	localparam logic [EE_DATA_W-1:0] EE_ERASED = '1;    // Erased cells read all ones

	typedef logic [EE_ADDR_W-1:0] ee_addr_t;
	typedef logic [EE_DATA_W-1:0] ee_word_t;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_READ,
		OP_WRITE,
		OP_ERASE,
		OP_ERAL,
		OP_WRAL,
		OP_EWEN,
		OP_EWDS
	} ee_op_t;

	// Two-bit opcode after the start bit
	localparam logic [1:0] OPC_EXT   = 2'b00;           // Extended group, see below
	localparam logic [1:0] OPC_WRITE = 2'b01;
	localparam logic [1:0] OPC_READ  = 2'b10;
	localparam logic [1:0] OPC_ERASE = 2'b11;

	// Extended codes, top two address bits when the opcode is 00
	localparam logic [1:0] EXT_EWDS = 2'b00;
	localparam logic [1:0] EXT_WRAL = 2'b01;
	localparam logic [1:0] EXT_ERAL = 2'b10;
	localparam logic [1:0] EXT_EWEN = 2'b11;

	// The 8 bits after the start bit, seen as address or as extended code
	typedef union packed {
		struct packed {
			logic [1:0] opc;
			ee_addr_t   addr;
		} adr;
		struct packed {
			logic [1:0] opc;
			logic [1:0] code;
			logic [3:0] dc;                             // Don't care bits
		} ext;
	} ee_instr_u;

endpackage

`default_nettype wire

/* design/ee_read_shifter.sv */
`timescale 1ns/100ps
`default_nettype none

module ee_read_shifter (
	input  wire               sys_clk,
	input  wire               xresetl,
	input  wire               cs_i,
	input  wire               sk_rise_i,
	input  wire               cmd_stb_i,
	input  ee_pkg::ee_op_t    cmd_op_i,
	input  ee_pkg::ee_addr_t  cmd_addr_i,
	input  wire               busy_i,
	input  ee_pkg::ee_word_t  rd_data_i,
	output ee_pkg::ee_addr_t  rd_addr_o,
	output logic              do_o
);

	logic              rd_active;
	logic              rd_load;
	logic              out_bit;
	ee_pkg::ee_word_t  sr;

	assign rd_addr_o = cmd_addr_i;          // Array answers in the same cycle
	assign rd_load   = cmd_stb_i && (cmd_op_i == ee_pkg::OP_READ);

	always_ff @(posedge sys_clk) begin
		if (!cs_i) begin
			rd_active <= 1'b0;
			out_bit   <= 1'b1;
		end else if (rd_load) begin
			sr        <= rd_data_i;
			out_bit   <= 1'b0;              // Dummy zero
			rd_active <= 1'b1;
		end else if (sk_rise_i && rd_active) begin
			out_bit <= sr[ee_pkg::EE_DATA_W-1];
			sr      <= {sr[ee_pkg::EE_DATA_W-2:0], 1'b0};
		end

		if (!xresetl) begin
			rd_active <= 1'b0;
			out_bit   <= 1'b1;
		end
	end

	always_comb begin
		if (!cs_i)
			do_o = 1'b1;
		else if (busy_i)
			do_o = 1'b0;                    // Busy level during write
		else if (rd_active)
			do_o = out_bit;
		else
			do_o = 1'b1;                    // Ready
	end

	// Decoder must not hand over a READ while a write runs
	a_no_read_busy: assert property (@(posedge sys_clk) disable iff (!xresetl)
		rd_load |-> !busy_i);

endmodule

`default_nettype wire

/* design/ee_serial_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module ee_serial_decode (
	input  wire               sys_clk,
	input  wire               xresetl,
	input  wire               cs_i,
	input  wire               sk_i,
	input  wire               di_i,
	input  wire               busy_i,
	output logic              sk_rise_o,
	output logic              cmd_stb_o,
	output ee_pkg::ee_op_t    cmd_op_o,
	output ee_pkg::ee_addr_t  cmd_addr_o,
	output ee_pkg::ee_word_t  cmd_data_o
);

	localparam logic [1:0] D_IDLE  = 2'd0;  // Waiting for the start bit
	localparam logic [1:0] D_INSTR = 2'd1;
	localparam logic [1:0] D_DATA  = 2'd2;
	localparam logic [1:0] D_READ  = 2'd3;  // Read in progress

	logic [1:0]         state;
	logic [3:0]         cnt;                // Bit counter
	logic               sk_prev;
	logic               bit_take;
	ee_pkg::ee_instr_u  instr;
	ee_pkg::ee_instr_u  instr_nxt;
	ee_pkg::ee_word_t   data_sr;
	ee_pkg::ee_op_t     op_nxt;
	ee_pkg::ee_op_t     op_q;

	function automatic ee_pkg::ee_op_t decode_op(input ee_pkg::ee_instr_u ir);
		ee_pkg::ee_op_t op;
		op = ee_pkg::OP_NONE;
		case (ir.adr.opc)
			ee_pkg::OPC_READ:  op = ee_pkg::OP_READ;
			ee_pkg::OPC_WRITE: op = ee_pkg::OP_WRITE;
			ee_pkg::OPC_ERASE: op = ee_pkg::OP_ERASE;
			ee_pkg::OPC_EXT: begin
				// Address bits carry the command here
				case (ir.ext.code)
					ee_pkg::EXT_EWEN: op = ee_pkg::OP_EWEN;
					ee_pkg::EXT_ERAL: op = ee_pkg::OP_ERAL;
					ee_pkg::EXT_WRAL: op = ee_pkg::OP_WRAL;
					ee_pkg::EXT_EWDS: op = ee_pkg::OP_EWDS;
				endcase
			end
		endcase
		return op;
	endfunction

	assign sk_rise_o = cs_i & sk_i & ~sk_prev;
	assign bit_take  = sk_rise_o & ~busy_i;         // Bits dropped during internal write

	// Instruction word as it will be after this bit
	assign instr_nxt = {instr[6:0], di_i};
	assign op_nxt    = decode_op(instr_nxt);

	assign cmd_op_o   = op_q;
	assign cmd_addr_o = instr.adr.addr;
	assign cmd_data_o = data_sr;

	always_ff @(posedge sys_clk) begin
		sk_prev   <= sk_i;
		cmd_stb_o <= 1'b0;
		if (!cs_i) begin
			state <= D_IDLE;
			cnt   <= '0;
		end else if (bit_take) begin
			case (state)
				D_IDLE: begin
					cnt <= '0;
					if (di_i)
						state <= D_INSTR;       // Start bit
				end
				D_INSTR: begin
					instr <= instr_nxt;
					cnt   <= cnt + 4'd1;
					if (cnt == 4'd7) begin
						op_q <= op_nxt;
						cnt  <= '0;
						if (op_nxt == ee_pkg::OP_WRITE || op_nxt == ee_pkg::OP_WRAL) begin
							state <= D_DATA;    // Data word follows
						end else begin
							cmd_stb_o <= 1'b1;
							state     <= (op_nxt == ee_pkg::OP_READ) ? D_READ : D_IDLE;
						end
					end
				end
				D_DATA: begin
					data_sr <= {data_sr[ee_pkg::EE_DATA_W-2:0], di_i};  // MSB first
					cnt     <= cnt + 4'd1;
					if (cnt == 4'd15) begin
						cmd_stb_o <= 1'b1;
						state     <= D_IDLE;
					end
				end
				default: begin
					// Stay here until cs_i drops
					state <= D_READ;
				end
			endcase
		end

		if (!xresetl) begin
			sk_prev   <= 1'b0;
			cmd_stb_o <= 1'b0;
			state     <= D_IDLE;
			cnt       <= '0;
			op_q      <= ee_pkg::OP_NONE;
		end
	end

	// One command per instruction, each needs a fresh sk edge
	a_stb_single: assert property (@(posedge sys_clk) disable iff (!xresetl)
		cmd_stb_o |=> !cmd_stb_o);

endmodule

`default_nettype wire

/* design/ee_write_engine.sv */
`timescale 1ns/100ps
`default_nettype none

module ee_write_engine (
	input  wire               sys_clk,
	input  wire               xresetl,
	input  wire               cmd_stb_i,
	input  ee_pkg::ee_op_t    cmd_op_i,
	input  ee_pkg::ee_addr_t  cmd_addr_i,
	input  ee_pkg::ee_word_t  cmd_data_i,
	output logic              busy_o,
	output logic              wr_en_o,
	output ee_pkg::ee_addr_t  wr_addr_o,
	output ee_pkg::ee_word_t  wr_data_o
);

	localparam logic [2:0] W_IDLE  = 3'd0;
	localparam logic [2:0] W_BEGIN = 3'd1;
	localparam logic [2:0] W_WRITE = 3'd2;
	localparam logic [2:0] W_LOOP  = 3'd3;
	localparam logic [2:0] W_END   = 3'd4;

	logic [2:0]        state;
	logic              wen;                 // Write enable flag, EWEN/EWDS
	logic              wr_loop;             // Walk all addresses
	logic              write_class;
	logic              all_words;
	logic              erase_op;
	ee_pkg::ee_addr_t  wraddr;
	ee_pkg::ee_word_t  wrdata;

	assign write_class = cmd_op_i inside {ee_pkg::OP_WRITE, ee_pkg::OP_ERASE,
		ee_pkg::OP_ERAL, ee_pkg::OP_WRAL};
	assign all_words = (cmd_op_i == ee_pkg::OP_ERAL) || (cmd_op_i == ee_pkg::OP_WRAL);
	assign erase_op  = (cmd_op_i == ee_pkg::OP_ERASE) || (cmd_op_i == ee_pkg::OP_ERAL);

	assign busy_o    = (state != W_IDLE);
	assign wr_en_o   = (state == W_WRITE) && wen;   // Sequence runs even with wen clear
	assign wr_addr_o = wraddr;
	assign wr_data_o = wrdata;

	always_ff @(posedge sys_clk) begin
		case (state)
			W_IDLE: begin
				if (cmd_stb_i) begin
					case (cmd_op_i)
						ee_pkg::OP_EWEN: wen <= 1'b1;
						ee_pkg::OP_EWDS: wen <= 1'b0;
						default: wen <= wen;
					endcase
					if (write_class) begin
						state   <= W_BEGIN;
						wr_loop <= all_words;
						wraddr  <= all_words ? '0 : cmd_addr_i;
						wrdata  <= erase_op ? ee_pkg::EE_ERASED : cmd_data_i;
					end
				end
			end
			W_BEGIN: state <= W_WRITE;
			W_WRITE: state <= W_LOOP;               // Cell written this cycle
			W_LOOP: begin
				if (wr_loop && wraddr != '1) begin
					wraddr <= wraddr + ee_pkg::ee_addr_t'(1);
					state  <= W_WRITE;
				end else begin
					state <= W_END;
				end
			end
			W_END: state <= W_IDLE;
			default: state <= W_IDLE;
		endcase

		if (!xresetl) begin
			state   <= W_IDLE;
			wen     <= 1'b0;
			wr_loop <= 1'b0;
		end
	end

	// Flag stays put for the whole sequence
	a_wr_needs_wen: assert property (@(posedge sys_clk) disable iff (!xresetl)
		wr_en_o |-> wen && $stable(wen));

	// Busy only ever starts from a decoded command
	a_busy_from_cmd: assert property (@(posedge sys_clk) disable iff (!xresetl)
		$rose(busy_o) |-> $past(cmd_stb_i));

endmodule

`default_nettype wire

/* design/eeprom_93c46.sv */
`timescale 1ns/100ps
`default_nettype none

module eeprom_93c46 (
	input  wire  sys_clk,
	input  wire  xresetl,
	input  wire  cs_i,
	input  wire  sk_i,
	input  wire  di_i,
	output logic do_o
);

	logic              sk_rise;
	logic              cmd_stb;
	ee_pkg::ee_op_t    cmd_op;
	ee_pkg::ee_addr_t  cmd_addr;
	ee_pkg::ee_word_t  cmd_data;
	logic              busy;
	logic              wr_en;
	ee_pkg::ee_addr_t  wr_addr;
	ee_pkg::ee_word_t  wr_data;
	ee_pkg::ee_addr_t  rd_addr;
	ee_pkg::ee_word_t  rd_data;

	ee_serial_decode decode (
		.sys_clk    (sys_clk),
		.xresetl    (xresetl),
		.cs_i       (cs_i),
		.sk_i       (sk_i),
		.di_i       (di_i),
		.busy_i     (busy),
		.sk_rise_o  (sk_rise),
		.cmd_stb_o  (cmd_stb),
		.cmd_op_o   (cmd_op),
		.cmd_addr_o (cmd_addr),
		.cmd_data_o (cmd_data)
	);

	ee_write_engine execute (
		.sys_clk    (sys_clk),
		.xresetl    (xresetl),
		.cmd_stb_i  (cmd_stb),
		.cmd_op_i   (cmd_op),
		.cmd_addr_i (cmd_addr),
		.cmd_data_i (cmd_data),
		.busy_o     (busy),
		.wr_en_o    (wr_en),
		.wr_addr_o  (wr_addr),
		.wr_data_o  (wr_data)
	);

	ee_cell_array cells (
		.sys_clk    (sys_clk),
		.wr_en_i    (wr_en),
		.wr_addr_i  (wr_addr),
		.wr_data_i  (wr_data),
		.rd_addr_i  (rd_addr),
		.rd_data_o  (rd_data)
	);

	ee_read_shifter result (
		.sys_clk    (sys_clk),
		.xresetl    (xresetl),
		.cs_i       (cs_i),
		.sk_rise_i  (sk_rise),
		.cmd_stb_i  (cmd_stb),
		.cmd_op_i   (cmd_op),
		.cmd_addr_i (cmd_addr),
		.busy_i     (busy),
		.rd_data_i  (rd_data),
		.rd_addr_o  (rd_addr),
		.do_o       (do_o)
	);

endmodule

`default_nettype wire
